// File: verilog/soc_dev_pkg.sv
package soc_dev_pkg;

    // ------------------------------------------------------------------------
    // Bus widths and master count
    // ------------------------------------------------------------------------
    localparam int XLEN        = 32;
    localparam int BE_W        = XLEN / 8;       // One enable per byte lane
    localparam int NUM_MASTERS = 2;
    localparam int MASTER_ID_W = 1;

    typedef logic [XLEN-1:0]        addr_t;
    typedef logic [XLEN-1:0]        data_t;
    typedef logic [BE_W-1:0]        be_t;
    typedef logic [MASTER_ID_W-1:0] master_id_t;

    // ------------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------------
    localparam int DEV_PAGE_MSB = 31;            // Top address byte picks the device
    localparam int DEV_PAGE_LSB = 24;
    localparam logic [DEV_PAGE_MSB-DEV_PAGE_LSB:0] UART_PAGE = 8'hC0;

    localparam int UART_REG_MSB = 3;             // Word-aligned register index
    localparam int UART_REG_LSB = 2;

    typedef enum logic {
        TGT_UART,
        TGT_NONE                                 // Unmapped page, answered locally
    } dev_target_e;

    typedef enum logic [UART_REG_MSB-UART_REG_LSB:0] {
        UART_REG_TXDATA = 2'd0,
        UART_REG_STATUS = 2'd1
    } uart_reg_e;

    // UART serial timing
    localparam int CLK_PER_BIT    = 16;
    localparam int UART_DATA_BITS = 8;
    localparam int CYC_CNT_W      = $clog2(CLK_PER_BIT);
    localparam int BIT_CNT_W      = $clog2(UART_DATA_BITS);

    typedef enum logic {ARB_IDLE, ARB_WAIT} arb_state_e;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

endpackage

// File: verilog/dev_bus_if.sv
interface dev_bus_if
    import soc_dev_pkg::*;
();

    // Request, driven by the master
    logic  strobe;                               // One-cycle pulse per request
    addr_t addr;
    logic  we;                                   // 1 for write, 0 for read
    be_t   be;
    data_t wdata;

    // Response, driven by the slave
    logic  ready;                                // One-cycle pulse, rdata valid
    data_t rdata;

    modport master (
        output strobe, addr, we, be, wdata,
        input  ready, rdata
    );

    modport slave (
        input  strobe, addr, we, be, wdata,
        output ready, rdata
    );

endinterface

// File: verilog/dev_arbiter.sv
module dev_arbiter
    import soc_dev_pkg::*;
(
    input  logic                   clk,
    input  logic                   usr_reset,

    // Per-master request side
    input  logic [NUM_MASTERS-1:0] m_strobe_i,
    input  addr_t                  m_addr_i  [NUM_MASTERS],
    input  logic [NUM_MASTERS-1:0] m_we_i,
    input  be_t                    m_be_i    [NUM_MASTERS],
    input  data_t                  m_wdata_i [NUM_MASTERS],
    output logic [NUM_MASTERS-1:0] m_ready_o,
    output data_t                  m_rdata_o [NUM_MASTERS],

    // Shared device bus toward the decoder
    dev_bus_if.master              bus
);

    arb_state_e             state_q;
    master_id_t             grant_q;             // Master owning the bus
    master_id_t             grant_idx;
    logic                   any_pending;
    logic                   bus_strobe_q;
    logic [NUM_MASTERS-1:0] pending_q;
    logic [NUM_MASTERS-1:0] resp_sel;

    addr_t                  req_addr_q  [NUM_MASTERS];
    logic [NUM_MASTERS-1:0] req_we_q;
    be_t                    req_be_q    [NUM_MASTERS];
    data_t                  req_wdata_q [NUM_MASTERS];

    // ------------------------------------------------------------------------
    // Request capture, one slot per master
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        for (int k = 0; k < NUM_MASTERS; k++) begin
            if (m_strobe_i[k]) begin             // Payload held until served
                req_addr_q[k]  <= m_addr_i[k];
                req_we_q[k]    <= m_we_i[k];
                req_be_q[k]    <= m_be_i[k];
                req_wdata_q[k] <= m_wdata_i[k];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (usr_reset) begin
            pending_q <= '0;
        end else begin
            for (int k = 0; k < NUM_MASTERS; k++) begin
                if (m_strobe_i[k])
                    pending_q[k] <= 1'b1;
                else if (m_ready_o[k])           // Served, slot free again
                    pending_q[k] <= 1'b0;
            end
        end
    end

    // Fixed priority, lowest index wins
    always_comb begin
        grant_idx   = '0;
        any_pending = |pending_q;
        for (int k = NUM_MASTERS - 1; k >= 0; k--) begin
            if (pending_q[k])
                grant_idx = master_id_t'(k);
        end
    end

    // ------------------------------------------------------------------------
    // Grant FSM, one request on the bus at a time
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (usr_reset) begin
            state_q      <= ARB_IDLE;
            grant_q      <= '0;
            bus_strobe_q <= 1'b0;
        end else begin
            bus_strobe_q <= 1'b0;                // Strobe lasts one cycle
            case (state_q)
                ARB_IDLE: begin
                    if (any_pending) begin
                        grant_q      <= grant_idx;
                        bus_strobe_q <= 1'b1;
                        state_q      <= ARB_WAIT;
                    end
                end
                ARB_WAIT: begin
                    if (bus.ready)
                        state_q <= ARB_IDLE;
                end
                default: state_q <= ARB_IDLE;
            endcase
        end
    end

    // Granted request straight from its slot
    assign bus.strobe = bus_strobe_q;
    assign bus.addr   = req_addr_q[grant_q];
    assign bus.we     = req_we_q[grant_q];
    assign bus.be     = req_be_q[grant_q];
    assign bus.wdata  = req_wdata_q[grant_q];

    // Response back to the granted master only
    always_comb begin
        for (int k = 0; k < NUM_MASTERS; k++) begin
            resp_sel[k]  = (state_q == ARB_WAIT) && (grant_q == master_id_t'(k));
            m_ready_o[k] = resp_sel[k] & bus.ready;
            m_rdata_o[k] = resp_sel[k] ? bus.rdata : '0;
        end
    end

endmodule

// File: verilog/dev_decode.sv
module dev_decode
    import soc_dev_pkg::*;
(
    input  logic      clk,
    input  logic      usr_reset,
    dev_bus_if.slave  host,                      // From the arbiter
    dev_bus_if.master uart                       // To the UART controller
);

    dev_target_e target;
    logic        none_ready_q;                   // Local answer for unmapped pages

    // ------------------------------------------------------------------------
    // Page decode
    // ------------------------------------------------------------------------
    // Address is held by the arbiter until ready, so the target stays valid
    // for the whole access and also steers the response
    always_comb begin
        if (host.addr[DEV_PAGE_MSB:DEV_PAGE_LSB] == UART_PAGE)
            target = TGT_UART;
        else
            target = TGT_NONE;
    end

    // Forward to the UART, strobe gated by the target
    assign uart.strobe = host.strobe && (target == TGT_UART);
    assign uart.addr   = host.addr;
    assign uart.we     = host.we;
    assign uart.be     = host.be;
    assign uart.wdata  = host.wdata;

    // Unmapped access gets ready one cycle after its strobe
    always_ff @(posedge clk) begin
        if (usr_reset)
            none_ready_q <= 1'b0;
        else
            none_ready_q <= host.strobe && (target == TGT_NONE);
    end

    // ------------------------------------------------------------------------
    // Response mux
    // ------------------------------------------------------------------------
    always_comb begin
        case (target)
            TGT_UART: begin
                host.ready = uart.ready;
                host.rdata = uart.rdata;
            end
            default: begin
                host.ready = none_ready_q;
                host.rdata = '0;                 // Unmapped reads return zero
            end
        endcase
    end

endmodule

// File: verilog/uart_tx_dev.sv
module uart_tx_dev
    import soc_dev_pkg::*;
(
    input  logic     clk,
    input  logic     usr_reset,
    dev_bus_if.slave bus,
    output logic     uart_tx_o
);

    logic [UART_REG_MSB-UART_REG_LSB:0] reg_idx;
    logic                               busy;
    logic                               start;
    logic                               bit_end;     // Last cycle of a serial bit

    tx_state_e                          state_q;
    logic [CYC_CNT_W-1:0]               cyc_cnt_q;
    logic [BIT_CNT_W-1:0]               bit_cnt_q;
    logic [UART_DATA_BITS-1:0]          shift_q;     // LSB goes out first
    logic                               ready_q;
    data_t                              rdata_q;

    assign reg_idx = bus.addr[UART_REG_MSB:UART_REG_LSB];
    assign busy    = (state_q != TX_IDLE);

    // TX data write with lane 0 enabled, dropped while a frame is running
    assign start = bus.strobe && bus.we && bus.be[0]
                && (reg_idx == UART_REG_TXDATA) && !busy;

    // ------------------------------------------------------------------------
    // Register access, every strobe is acknowledged
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (usr_reset)
            ready_q <= 1'b0;
        else
            ready_q <= bus.strobe;
    end

    always_ff @(posedge clk) begin
        if (bus.strobe) begin
            if (!bus.we && (reg_idx == UART_REG_STATUS))
                rdata_q <= {{(XLEN-1){1'b0}}, busy};  // Bit 0 is TX busy
            else
                rdata_q <= '0;
        end
    end

    assign bus.ready = ready_q;
    assign bus.rdata = rdata_q;

    // ------------------------------------------------------------------------
    // Frame generator, start bit, data bits, stop bit
    // ------------------------------------------------------------------------
    assign bit_end = (cyc_cnt_q == CYC_CNT_W'(CLK_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (usr_reset) begin
            state_q   <= TX_IDLE;
            cyc_cnt_q <= '0;
            bit_cnt_q <= '0;
        end else begin
            if (state_q == TX_IDLE || bit_end)
                cyc_cnt_q <= '0;
            else
                cyc_cnt_q <= cyc_cnt_q + 1'b1;

            case (state_q)
                TX_IDLE: begin
                    if (start)
                        state_q <= TX_START;
                end
                TX_START: begin
                    if (bit_end) begin
                        bit_cnt_q <= '0;
                        state_q   <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                        if (bit_cnt_q == BIT_CNT_W'(UART_DATA_BITS - 1))
                            state_q <= TX_STOP;      // All data bits sent
                    end
                end
                TX_STOP: begin
                    if (bit_end)
                        state_q <= TX_IDLE;
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // Byte loaded on start, shifted at the end of each data bit
    always_ff @(posedge clk) begin
        if (start)
            shift_q <= bus.wdata[UART_DATA_BITS-1:0];
        else if (state_q == TX_DATA && bit_end)
            shift_q <= shift_q >> 1;
    end

    // Line idles high
    always_comb begin
        case (state_q)
            TX_START: uart_tx_o = 1'b0;
            TX_DATA:  uart_tx_o = shift_q[0];
            default:  uart_tx_o = 1'b1;
        endcase
    end

endmodule

// File: verilog/soc_dev_top.sv
module soc_dev_top
    import soc_dev_pkg::*;
(
    input  logic                   clk,
    input  logic                   usr_reset,

    // Device bus ports, one set per master
    input  logic [NUM_MASTERS-1:0] m_strobe_i,
    input  addr_t                  m_addr_i  [NUM_MASTERS],
    input  logic [NUM_MASTERS-1:0] m_we_i,
    input  be_t                    m_be_i    [NUM_MASTERS],
    input  data_t                  m_wdata_i [NUM_MASTERS],
    output logic [NUM_MASTERS-1:0] m_ready_o,
    output data_t                  m_rdata_o [NUM_MASTERS],

    output logic                   uart_tx_o     // Serial line, idle high
);

    dev_bus_if arb_bus ();                       // Arbiter to decoder
    dev_bus_if uart_bus ();                      // Decoder to UART

    // ------------------------------------------------------------------------
    // Arbiter, decoder, UART
    // ------------------------------------------------------------------------
    dev_arbiter arb0 (
        .clk        (clk),
        .usr_reset  (usr_reset),
        .m_strobe_i (m_strobe_i),
        .m_addr_i   (m_addr_i),
        .m_we_i     (m_we_i),
        .m_be_i     (m_be_i),
        .m_wdata_i  (m_wdata_i),
        .m_ready_o  (m_ready_o),
        .m_rdata_o  (m_rdata_o),
        .bus        (arb_bus.master)
    );

    dev_decode dec0 (
        .clk        (clk),
        .usr_reset  (usr_reset),
        .host       (arb_bus.slave),
        .uart       (uart_bus.master)
    );

    // Page C0, transmit only
    uart_tx_dev uart0 (
        .clk        (clk),
        .usr_reset  (usr_reset),
        .bus        (uart_bus.slave),
        .uart_tx_o  (uart_tx_o)
    );

endmodule

// File: dv/tb_soc_dev_tasks.svh
`ifndef TB_SOC_DEV_TASKS_SVH
`define TB_SOC_DEV_TASKS_SVH

    // ------------------------------------------------------------------------
    // Typed compares
    // ------------------------------------------------------------------------
    task automatic cmp_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic cmp_byte(input string name, input logic [UART_DATA_BITS-1:0] got,
                            input logic [UART_DATA_BITS-1:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic cmp_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        else
            return s >> 1;
    endfunction

    // One LFSR step per payload bit
    task automatic next_byte(output logic [UART_DATA_BITS-1:0] b);
        for (int i = 0; i < UART_DATA_BITS; i++) begin
            b[i]   = lfsr_q[0];
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // Register address inside the UART page
    function automatic addr_t uart_addr(input uart_reg_e r);
        addr_t a;
        a = '0;
        a[DEV_PAGE_MSB:DEV_PAGE_LSB] = UART_PAGE;
        a[UART_REG_MSB:UART_REG_LSB] = r;
        return a;
    endfunction

    // ------------------------------------------------------------------------
    // Bus access and serial capture
    // ------------------------------------------------------------------------
    task automatic bus_access(input int m, input addr_t addr, input logic we, input be_t be,
                              input data_t wdata, output data_t rdata);
        int waited;
        @(posedge clk);
        m_strobe_i[m] <= 1'b1;
        m_addr_i[m]   <= addr;
        m_we_i[m]     <= we;
        m_be_i[m]     <= be;
        m_wdata_i[m]  <= wdata;
        @(posedge clk);
        m_strobe_i[m] <= 1'b0;                       // One-cycle strobe
        waited = 0;
        @(negedge clk);
        while (!m_ready_o[m]) begin
            waited++;
            if (waited > 10) begin
                $display("No ready on master %0d within 10 cycles of its strobe", m);
                abort_run();
            end
            @(negedge clk);
        end
        ready_at[m] = $time;                         // Used for grant order
        rdata       = m_rdata_o[m];
    endtask

    // Samples mid-bit, returns once the stop bit is over
    task automatic capture_frame(output logic [UART_DATA_BITS-1:0] payload);
        @(negedge uart_tx_o);
        repeat (CLK_PER_BIT / 2) @(negedge clk);
        cmp_bit("uart_tx_o start bit", uart_tx_o, 1'b0);
        for (int i = 0; i < UART_DATA_BITS; i++) begin
            repeat (CLK_PER_BIT) @(negedge clk);
            payload[i] = uart_tx_o;                  // LSB first
        end
        repeat (CLK_PER_BIT) @(negedge clk);
        cmp_bit("uart_tx_o stop bit", uart_tx_o, 1'b1);
        repeat (CLK_PER_BIT / 2 + 1) @(negedge clk);
    endtask

    task automatic check_line_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            cmp_bit("uart_tx_o", uart_tx_o, 1'b1);
        end
    endtask

`endif

// File: dv/tb_soc_dev.sv
module tb_soc_dev
    import soc_dev_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int NUM_RANDOM = 8;
    localparam int NUM_FRAMES = 2 + NUM_RANDOM;  // Single byte, contention, random bytes

    logic                   clk;
    logic                   usr_reset;
    logic [NUM_MASTERS-1:0] m_strobe_i;
    addr_t                  m_addr_i  [NUM_MASTERS];
    logic [NUM_MASTERS-1:0] m_we_i;
    be_t                    m_be_i    [NUM_MASTERS];
    data_t                  m_wdata_i [NUM_MASTERS];
    logic [NUM_MASTERS-1:0] m_ready_o;
    data_t                  m_rdata_o [NUM_MASTERS];
    logic                   uart_tx_o;

    logic [31:0]            lfsr_q;              // Random byte source
    time                    ready_at  [NUM_MASTERS];

    soc_dev_top dut0 (
        .clk        (clk),
        .usr_reset  (usr_reset),
        .m_strobe_i (m_strobe_i),
        .m_addr_i   (m_addr_i),
        .m_we_i     (m_we_i),
        .m_be_i     (m_be_i),
        .m_wdata_i  (m_wdata_i),
        .m_ready_o  (m_ready_o),
        .m_rdata_o  (m_rdata_o),
        .uart_tx_o  (uart_tx_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Ends the run at the first failure
    task automatic abort_run();
        $display("Regression failed");
        $fatal(1, "Stopped at first failure");
    endtask

`include "tb_soc_dev_tasks.svh"

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic check_after_reset();
        data_t rd;
        @(negedge clk);
        cmp_bit("uart_tx_o", uart_tx_o, 1'b1);       // Line idles high
        bus_access(0, uart_addr(UART_REG_STATUS), 1'b0, '1, '0, rd);
        cmp_data("m_rdata_o[0]", rd, '0);
    endtask

    task automatic send_one_byte();
        logic [UART_DATA_BITS-1:0] seen;
        data_t                     rd;
        fork
            capture_frame(seen);
            begin
                bus_access(0, uart_addr(UART_REG_TXDATA), 1'b1, 4'h1, 32'h0000_00a5, rd);
                bus_access(0, uart_addr(UART_REG_STATUS), 1'b0, '1, '0, rd);
                cmp_data("m_rdata_o[0]", rd, 32'h1); // Busy while the frame runs
            end
        join
        cmp_byte("uart_tx_o frame", seen, 8'ha5);
        bus_access(0, uart_addr(UART_REG_STATUS), 1'b0, '1, '0, rd);
        cmp_data("m_rdata_o[0]", rd, '0);
    endtask

    // Page 40 has no device behind it
    task automatic access_unmapped_page();
        data_t rd;
        bus_access(1, 32'h4000_0000, 1'b1, 4'h1, 32'h0000_005a, rd);
        cmp_data("m_rdata_o[1]", rd, '0);
        bus_access(1, 32'h4000_0004, 1'b0, '1, '0, rd);
        cmp_data("m_rdata_o[1]", rd, '0);
        check_line_idle(CLK_PER_BIT / 2);
    endtask

    task automatic contend_two_masters();
        logic [UART_DATA_BITS-1:0] seen;
        data_t                     rd0;
        data_t                     rd1;
        fork
            capture_frame(seen);
            bus_access(0, uart_addr(UART_REG_TXDATA), 1'b1, 4'h1, 32'h0000_003c, rd0);
            bus_access(1, uart_addr(UART_REG_TXDATA), 1'b1, 4'h1, 32'h0000_00c3, rd1);
        join
        cmp_bit("m_ready_o[0] before m_ready_o[1]", ready_at[0] < ready_at[1], 1'b1);
        cmp_byte("uart_tx_o frame", seen, 8'h3c);    // Master 1 hit a busy UART
        check_line_idle(CLK_PER_BIT / 2);
    endtask

    task automatic send_random_bytes();
        logic [UART_DATA_BITS-1:0] sent;
        logic [UART_DATA_BITS-1:0] seen;
        data_t                     rd;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            next_byte(sent);
            fork
                capture_frame(seen);
                bus_access(i % NUM_MASTERS, uart_addr(UART_REG_TXDATA), 1'b1, 4'h1,
                           data_t'(sent), rd);
            join
            cmp_byte("uart_tx_o frame", seen, sent);
        end
    endtask

    // ------------------------------------------------------------------------
    // Watchdog and sequence
    // ------------------------------------------------------------------------
    initial begin
        #(NUM_FRAMES * 10 * CLK_PER_BIT * CLK_PERIOD + 2000);
        $display("Watchdog expired before the test sequence finished");
        abort_run();
    end

    initial begin
        clk        = 1'b0;
        usr_reset  = 1'b1;
        m_strobe_i = '0;
        m_we_i     = '0;
        lfsr_q     = 32'h25ef;
        for (int k = 0; k < NUM_MASTERS; k++) begin
            m_addr_i[k]  = '0;
            m_be_i[k]    = '0;
            m_wdata_i[k] = '0;
            ready_at[k]  = 0;
        end
        repeat (16) @(posedge clk);
        usr_reset <= 1'b0;

        check_after_reset();
        send_one_byte();
        access_unmapped_page();
        contend_two_masters();
        send_random_bytes();

        $display("Regression passed");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+dv
verilog/soc_dev_pkg.sv
verilog/dev_bus_if.sv
verilog/dev_arbiter.sv
verilog/dev_decode.sv
verilog/uart_tx_dev.sv
verilog/soc_dev_top.sv
dv/tb_soc_dev.sv

// File: run.sh
#!/bin/sh
# Build and run the device bus regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_soc_dev \
    -f filelist.f --Mdir obj_dir > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/Vtb_soc_dev > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
